/* src/seq_pkg.sv */
`default_nettype none

package seq_pkg;

    ////////////////////
    // Base alphabet
    ////////////////////

    localparam int BASE_W = 2;

    // Two-bit encoding, one code per nucleotide
    typedef enum logic [BASE_W-1:0] {
        BASE_A = 2'd0,
        BASE_C = 2'd1,
        BASE_G = 2'd2,
        BASE_T = 2'd3
    } base_e;

    ////////////////////
    // Array geometry
    ////////////////////

    // One processing element per query base
    localparam int PE_NUM = 4;
    localparam int COL_W  = $clog2(PE_NUM);

    // Database rows are counted from the first-marked beat
    localparam int DB_MAX_LEN = 256;
    localparam int ROW_W      = $clog2(DB_MAX_LEN);

endpackage

`default_nettype wire

/* src/score_pkg.sv */
`default_nettype none

package score_pkg;

    ////////////////////
    // Score format
    ////////////////////

    // Signed, wide enough for any local score over DB_MAX_LEN rows
    localparam int SCORE_W = 16;

    ////////////////////
    // Substitution
    ////////////////////

    localparam logic signed [SCORE_W-1:0] MATCH_SCORE    = 16'sd2;
    localparam logic signed [SCORE_W-1:0] MISMATCH_SCORE = -16'sd1;

    ////////////////////
    // Affine gaps
    ////////////////////

    // First base of a gap costs GAP_OPEN, each one after it GAP_EXTEND
    localparam logic signed [SCORE_W-1:0] GAP_OPEN   = 16'sd3;
    localparam logic signed [SCORE_W-1:0] GAP_EXTEND = 16'sd1;

    // No gap open yet; far below any reachable score
    localparam logic signed [SCORE_W-1:0] SCORE_NEG_INF = -16'sd4096;

endpackage

`default_nettype wire

/* src/sw_cell.sv */
`default_nettype none

module sw_cell (
    input  wire                                   sys_clk,
    input  wire                                   sys_rst_n,
    input  wire seq_pkg::base_e                   query_base_i,
    input  wire                                   valid_i,
    input  wire                                   first_i,
    input  wire                                   last_i,
    input  wire seq_pkg::base_e                   base_i,
    input  wire signed [score_pkg::SCORE_W-1:0]   h_left_i,
    input  wire signed [score_pkg::SCORE_W-1:0]   f_left_i,
    output logic                                  valid_o,
    output logic                                  first_o,
    output logic                                  last_o,
    output seq_pkg::base_e                        base_o,
    output logic signed [score_pkg::SCORE_W-1:0]  h_o,
    output logic signed [score_pkg::SCORE_W-1:0]  f_o,
    output logic [seq_pkg::ROW_W-1:0]             row_o
);

    // Column state carried from one database row to the next
    logic signed [score_pkg::SCORE_W-1:0] e_q;
    logic signed [score_pkg::SCORE_W-1:0] diag_q;

    logic signed [score_pkg::SCORE_W-1:0] h_up;
    logic signed [score_pkg::SCORE_W-1:0] e_up;
    logic signed [score_pkg::SCORE_W-1:0] diag;
    logic signed [score_pkg::SCORE_W-1:0] sub;
    logic signed [score_pkg::SCORE_W-1:0] h_diag;
    logic signed [score_pkg::SCORE_W-1:0] e_open;
    logic signed [score_pkg::SCORE_W-1:0] e_ext;
    logic signed [score_pkg::SCORE_W-1:0] f_open;
    logic signed [score_pkg::SCORE_W-1:0] f_ext;
    logic signed [score_pkg::SCORE_W-1:0] e_new;
    logic signed [score_pkg::SCORE_W-1:0] f_new;
    logic signed [score_pkg::SCORE_W-1:0] h_new;

    ////////////////////
    // Recurrence
    ////////////////////

    always_comb begin
        // Row above the first row is all zero with no vertical gap
        h_up = first_i ? '0 : h_o;
        e_up = first_i ? score_pkg::SCORE_NEG_INF : e_q;
        diag = first_i ? '0 : diag_q;

        sub = (base_i == query_base_i) ? score_pkg::MATCH_SCORE : score_pkg::MISMATCH_SCORE;
        h_diag = diag + sub;

        // Vertical gap, along the database
        e_open = h_up - score_pkg::GAP_OPEN;
        e_ext  = e_up - score_pkg::GAP_EXTEND;
        e_new  = (e_open > e_ext) ? e_open : e_ext;

        // Horizontal gap, along the query
        f_open = h_left_i - score_pkg::GAP_OPEN;
        f_ext  = f_left_i - score_pkg::GAP_EXTEND;
        f_new  = (f_open > f_ext) ? f_open : f_ext;

        // Local alignment floors at zero
        h_new = '0;
        if (h_diag > h_new) begin
            h_new = h_diag;
        end
        if (e_new > h_new) begin
            h_new = e_new;
        end
        if (f_new > h_new) begin
            h_new = f_new;
        end
    end

    ////////////////////
    // Registers
    ////////////////////

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            valid_o <= 1'b0;
            first_o <= 1'b0;
            last_o  <= 1'b0;
        end else begin
            valid_o <= valid_i;
            first_o <= valid_i & first_i;
            last_o  <= valid_i & last_i;
        end
    end

    // Everything holds while valid is low
    always_ff @(posedge sys_clk) begin
        if (valid_i) begin
            base_o <= base_i;
            h_o    <= h_new;
            f_o    <= f_new;
            e_q    <= e_new;
            diag_q <= h_left_i;
            row_o  <= first_i ? '0 : row_o + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/sw_best_tracker.sv */
`default_nettype none

module sw_best_tracker #(
    parameter int COL_INDEX = 0
) (
    input  wire                                   sys_clk,
    input  wire                                   sys_rst_n,
    input  wire                                   valid_i,
    input  wire                                   first_i,
    input  wire                                   last_i,
    input  wire signed [score_pkg::SCORE_W-1:0]   h_i,
    input  wire [seq_pkg::ROW_W-1:0]              row_i,
    input  wire                                   cand_valid_i,
    input  wire signed [score_pkg::SCORE_W-1:0]   cand_score_i,
    input  wire [seq_pkg::ROW_W-1:0]              cand_row_i,
    input  wire [seq_pkg::COL_W-1:0]              cand_col_i,
    output logic                                  cand_valid_o,
    output logic signed [score_pkg::SCORE_W-1:0]  cand_score_o,
    output logic [seq_pkg::ROW_W-1:0]             cand_row_o,
    output logic [seq_pkg::COL_W-1:0]             cand_col_o
);

    // Best H seen in this column so far, and where
    logic signed [score_pkg::SCORE_W-1:0] best_q;
    logic [seq_pkg::ROW_W-1:0]            best_row_q;

    logic                                 take_cur;
    logic                                 take_up;
    logic signed [score_pkg::SCORE_W-1:0] run_best;
    logic [seq_pkg::ROW_W-1:0]            run_row;

    always_comb begin
        // Strictly greater keeps the earliest row on a tie
        take_cur = first_i || (h_i > best_q);
        run_best = take_cur ? h_i : best_q;
        run_row  = take_cur ? row_i : best_row_q;

        // Upstream is a lower column, so it keeps ties
        take_up = cand_valid_i && (cand_score_i >= run_best);
    end

    ////////////////////
    // Column best
    ////////////////////

    always_ff @(posedge sys_clk) begin
        if (valid_i) begin
            best_q     <= run_best;
            best_row_q <= run_row;
        end
    end

    ////////////////////
    // Compare chain stage
    ////////////////////

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cand_valid_o <= 1'b0;
            cand_score_o <= '0;
            cand_row_o   <= '0;
            cand_col_o   <= '0;
        end else begin
            cand_valid_o <= valid_i & last_i;
            if (valid_i && last_i) begin
                if (take_up) begin
                    cand_score_o <= cand_score_i;
                    cand_row_o   <= cand_row_i;
                    cand_col_o   <= cand_col_i;
                end else begin
                    cand_score_o <= run_best;
                    cand_row_o   <= run_row;
                    cand_col_o   <= COL_INDEX[seq_pkg::COL_W-1:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/sw_top.sv */
`default_nettype none

module sw_top (
    input  wire                                         sys_clk,
    input  wire                                         sys_rst_n,
    input  wire [seq_pkg::PE_NUM*seq_pkg::BASE_W-1:0]   query_i,
    input  wire                                         db_valid_i,
    input  wire seq_pkg::base_e                         db_base_i,
    input  wire                                         db_first_i,
    input  wire                                         db_last_i,
    output logic                                        result_valid_o,
    output logic signed [score_pkg::SCORE_W-1:0]        result_score_o,
    output logic [seq_pkg::ROW_W-1:0]                   result_row_o,
    output logic [seq_pkg::COL_W-1:0]                   result_col_o
);

    ////////////////////
    // Cell chain nets
    ////////////////////

    // Index 0 is the external stream, index k+1 is cell k's output
    logic                                 pe_valid [0:seq_pkg::PE_NUM];
    logic                                 pe_first [0:seq_pkg::PE_NUM];
    logic                                 pe_last  [0:seq_pkg::PE_NUM];
    seq_pkg::base_e                       pe_base  [0:seq_pkg::PE_NUM];
    logic signed [score_pkg::SCORE_W-1:0] pe_h     [0:seq_pkg::PE_NUM];
    logic signed [score_pkg::SCORE_W-1:0] pe_f     [0:seq_pkg::PE_NUM];
    logic [seq_pkg::ROW_W-1:0]            pe_row   [0:seq_pkg::PE_NUM-1];

    ////////////////////
    // Compare chain nets
    ////////////////////

    logic                                 cand_valid [0:seq_pkg::PE_NUM];
    logic signed [score_pkg::SCORE_W-1:0] cand_score [0:seq_pkg::PE_NUM];
    logic [seq_pkg::ROW_W-1:0]            cand_row   [0:seq_pkg::PE_NUM];
    logic [seq_pkg::COL_W-1:0]            cand_col   [0:seq_pkg::PE_NUM];

    // Left edge of the matrix: zero H, no horizontal gap open
    assign pe_valid[0] = db_valid_i;
    assign pe_first[0] = db_first_i;
    assign pe_last[0]  = db_last_i;
    assign pe_base[0]  = db_base_i;
    assign pe_h[0]     = '0;
    assign pe_f[0]     = score_pkg::SCORE_NEG_INF;

    // Nothing upstream of column 0
    assign cand_valid[0] = 1'b0;
    assign cand_score[0] = '0;
    assign cand_row[0]   = '0;
    assign cand_col[0]   = '0;

    for (genvar k = 0; k < seq_pkg::PE_NUM; k++) begin : g_pe
        sw_cell sw_cell_inst (
            .sys_clk      (sys_clk),
            .sys_rst_n    (sys_rst_n),
            .query_base_i (seq_pkg::base_e'(query_i[k*seq_pkg::BASE_W +: seq_pkg::BASE_W])),
            .valid_i      (pe_valid[k]),
            .first_i      (pe_first[k]),
            .last_i       (pe_last[k]),
            .base_i       (pe_base[k]),
            .h_left_i     (pe_h[k]),
            .f_left_i     (pe_f[k]),
            .valid_o      (pe_valid[k+1]),
            .first_o      (pe_first[k+1]),
            .last_o       (pe_last[k+1]),
            .base_o       (pe_base[k+1]),
            .h_o          (pe_h[k+1]),
            .f_o          (pe_f[k+1]),
            .row_o        (pe_row[k])
        );

        // Sees its cell's outputs in step with the upstream candidate
        sw_best_tracker #(
            .COL_INDEX (k)
        ) sw_best_tracker_inst (
            .sys_clk      (sys_clk),
            .sys_rst_n    (sys_rst_n),
            .valid_i      (pe_valid[k+1]),
            .first_i      (pe_first[k+1]),
            .last_i       (pe_last[k+1]),
            .h_i          (pe_h[k+1]),
            .row_i        (pe_row[k]),
            .cand_valid_i (cand_valid[k]),
            .cand_score_i (cand_score[k]),
            .cand_row_i   (cand_row[k]),
            .cand_col_i   (cand_col[k]),
            .cand_valid_o (cand_valid[k+1]),
            .cand_score_o (cand_score[k+1]),
            .cand_row_o   (cand_row[k+1]),
            .cand_col_o   (cand_col[k+1])
        );
    end

    // Last stage of the compare chain is the alignment result
    assign result_valid_o = cand_valid[seq_pkg::PE_NUM];
    assign result_score_o = cand_score[seq_pkg::PE_NUM];
    assign result_row_o   = cand_row[seq_pkg::PE_NUM];
    assign result_col_o   = cand_col[seq_pkg::PE_NUM];

endmodule

`default_nettype wire

/* sim/sw_ref_model.svh */
`ifndef SW_REF_MODEL_SVH
`define SW_REF_MODEL_SVH

function automatic int max2(input int a, input int b);
    return (a > b) ? a : b;
endfunction

// Highest score first, then lowest column, then lowest row
function automatic bit beats_best(input int score, input int row, input int col,
                                  input expect_t best);
    if (score != best.score) begin
        return score > best.score;
    end
    if (col != best.col) begin
        return col < best.col;
    end
    return row < best.row;
endfunction

// Local alignment with affine gaps, rows in database order
task automatic score_alignment(
    input  logic [QUERY_BITS-1:0] q,
    input  logic [DB_BITS-1:0]    db,
    input  int                    len,
    output expect_t               res
);
    int h_up [seq_pkg::PE_NUM];
    int e_up [seq_pkg::PE_NUM];
    int h_left;
    int f_left;
    int diag;
    int e;
    int h;
    int i;
    int j;
    bit same;
    res = '0;
    res.score = -1;
    for (j = 0; j < seq_pkg::PE_NUM; j++) begin
        h_up[j] = 0;
        e_up[j] = int'(score_pkg::SCORE_NEG_INF);
    end
    for (i = 0; i < len; i++) begin
        // Left edge of every row
        h_left = 0;
        f_left = int'(score_pkg::SCORE_NEG_INF);
        diag   = 0;
        for (j = 0; j < seq_pkg::PE_NUM; j++) begin
            same = db[seq_pkg::BASE_W*i +: seq_pkg::BASE_W]
                == q[seq_pkg::BASE_W*j +: seq_pkg::BASE_W];
            e = max2(h_up[j] - int'(score_pkg::GAP_OPEN), e_up[j] - int'(score_pkg::GAP_EXTEND));
            f_left = max2(h_left - int'(score_pkg::GAP_OPEN),
                          f_left - int'(score_pkg::GAP_EXTEND));
            h = diag + (same ? int'(score_pkg::MATCH_SCORE) : int'(score_pkg::MISMATCH_SCORE));
            h = max2(max2(h, 0), max2(e, f_left));
            diag    = h_up[j];
            h_up[j] = h;
            e_up[j] = e;
            h_left  = h;
            if (beats_best(h, i, j, res)) begin
                res.score = h;
                res.row   = i;
                res.col   = j;
            end
        end
    end
endtask

`endif

/* sim/tb_sw_top.sv */
`default_nettype none

module tb_sw_top;

    localparam int CLK_PERIOD = 10;
    localparam int ENTRY_NUM  = 11;
    localparam int MAX_DB_LEN = 16;
    localparam int QUERY_BITS = seq_pkg::PE_NUM * seq_pkg::BASE_W;
    localparam int DB_BITS    = MAX_DB_LEN * seq_pkg::BASE_W;

    typedef struct packed {
        int score;
        int row;
        int col;
        int due;
    } expect_t;

    logic                                 sys_clk;
    logic                                 sys_rst_n;
    logic [QUERY_BITS-1:0]                query;
    logic                                 db_valid;
    seq_pkg::base_e                       db_base;
    logic                                 db_first;
    logic                                 db_last;
    logic                                 result_valid;
    logic signed [score_pkg::SCORE_W-1:0] result_score;
    logic [seq_pkg::ROW_W-1:0]            result_row;
    logic [seq_pkg::COL_W-1:0]            result_col;

    // Stimulus table
    logic [QUERY_BITS-1:0] tab_query  [ENTRY_NUM];
    logic [DB_BITS-1:0]    tab_db     [ENTRY_NUM];
    int                    tab_len    [ENTRY_NUM];
    bit                    tab_bubble [ENTRY_NUM];

    // Expected results, oldest last beat first
    expect_t exp_q[$];

    // Result fields must hold between results
    logic signed [score_pkg::SCORE_W-1:0] last_score = '0;
    logic [seq_pkg::ROW_W-1:0]            last_row = '0;
    logic [seq_pkg::COL_W-1:0]            last_col = '0;

    int     cycle_cnt = 0;
    int     check_cnt = 0;
    int     error_cnt = 0;
    int     timeout_cycles = 0;
    integer seed = 53;

    `include "sw_ref_model.svh"

    sw_top sw_top_inst (
        .sys_clk        (sys_clk),
        .sys_rst_n      (sys_rst_n),
        .query_i        (query),
        .db_valid_i     (db_valid),
        .db_base_i      (db_base),
        .db_first_i     (db_first),
        .db_last_i      (db_last),
        .result_valid_o (result_valid),
        .result_score_o (result_score),
        .result_row_o   (result_row),
        .result_col_o   (result_col)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [DB_BITS-1:0] pack_bases(input string s);
        logic [DB_BITS-1:0] bits;
        seq_pkg::base_e     b;
        int                 i;
        bits = '0;
        for (i = 0; i < s.len(); i++) begin
            case (s[i])
                "A":     b = seq_pkg::BASE_A;
                "C":     b = seq_pkg::BASE_C;
                "G":     b = seq_pkg::BASE_G;
                default: b = seq_pkg::BASE_T;
            endcase
            bits[seq_pkg::BASE_W*i +: seq_pkg::BASE_W] = b;
        end
        return bits;
    endfunction

    task automatic add_entry(input int idx, input string q, input string d, input bit bubble);
        logic [DB_BITS-1:0] q_bits;
        q_bits          = pack_bases(q);
        tab_query[idx]  = q_bits[QUERY_BITS-1:0];
        tab_db[idx]     = pack_bases(d);
        tab_len[idx]    = d.len();
        tab_bubble[idx] = bubble;
    endtask

    task automatic compare_value(input string name, input int got, input int want);
        check_cnt++;
        if (got != want) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, want);
            error_cnt++;
        end
    endtask

    task automatic check_result();
        expect_t expected;
        expected = exp_q.pop_front();
        compare_value("result_score_o", int'(result_score), expected.score);
        compare_value("result_row_o", int'(result_row), expected.row);
        compare_value("result_col_o", int'(result_col), expected.col);
        compare_value("result_valid_o cycle", cycle_cnt, expected.due);
    endtask

    task automatic send_sequence(input int idx);
        expect_t expected;
        int      i;
        int      gaps;
        if (query != tab_query[idx]) begin
            // Cells still busy with the old query until its result is out
            @(negedge sys_clk);
            db_valid = 1'b0;
            while (exp_q.size() != 0) begin
                @(negedge sys_clk);
            end
            query = tab_query[idx];
        end
        for (i = 0; i < tab_len[idx]; i++) begin
            gaps = (tab_bubble[idx] && i > 0) ? {$random(seed)} % 3 : 0;
            repeat (gaps) begin
                @(negedge sys_clk);
                db_valid = 1'b0;
            end
            @(negedge sys_clk);
            db_valid = 1'b1;
            db_base  = seq_pkg::base_e'(tab_db[idx][seq_pkg::BASE_W*i +: seq_pkg::BASE_W]);
            db_first = (i == 0);
            db_last  = (i == tab_len[idx] - 1);
        end
        score_alignment(tab_query[idx], tab_db[idx], tab_len[idx], expected);
        // Result registered PE_NUM+1 edges after the edge that launched the last beat
        expected.due = cycle_cnt + seq_pkg::PE_NUM + 1;
        exp_q.push_back(expected);
    endtask

    ////////////////////
    // Monitor
    ////////////////////

    always @(negedge sys_clk) begin
        if (result_valid) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected result_valid_o at cycle %0d", cycle_cnt);
                error_cnt++;
            end else begin
                check_result();
            end
            last_score = result_score;
            last_row   = result_row;
            last_col   = result_col;
        end else begin
            if (result_score !== last_score || result_row !== last_row
                    || result_col !== last_col) begin
                $display("Result fields changed without result_valid_o at cycle %0d", cycle_cnt);
                error_cnt++;
            end
            if (exp_q.size() != 0 && cycle_cnt >= exp_q[0].due) begin
                $display("No result by cycle %0d", exp_q[0].due);
                error_cnt++;
                void'(exp_q.pop_front());
            end
        end
    end

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int idx;
        int total_bases;
        sys_rst_n = 1'b0;
        query     = '0;
        db_valid  = 1'b0;
        db_base   = seq_pkg::BASE_A;
        db_first  = 1'b0;
        db_last   = 1'b0;

        add_entry(0, "ACGT", "ACGT", 1'b0);
        add_entry(1, "ACGT", "TTACGTAA", 1'b0);
        add_entry(2, "ACGT", "AGGT", 1'b0);
        add_entry(3, "ACGT", "ACAGT", 1'b0);
        add_entry(4, "ACGT", "ACTTTGT", 1'b0);
        add_entry(5, "ACGT", "AGT", 1'b0);
        add_entry(6, "ACGT", "G", 1'b0);
        add_entry(7, "ACGT", "GACGTTACGGTACCGT", 1'b0);
        add_entry(8, "ACGT", "GACGTTACGGTACCGT", 1'b1);
        add_entry(9, "TGCA", "TTGGCCAATGCATGCA", 1'b1);
        add_entry(10, "AAAA", "CGTC", 1'b0);

        total_bases = 0;
        for (idx = 0; idx < ENTRY_NUM; idx++) begin
            total_bases += tab_len[idx];
        end
        timeout_cycles = 20 * ENTRY_NUM + total_bases;

        repeat (10) @(negedge sys_clk);
        sys_rst_n = 1'b1;
        // Idle stretch, any result here is flagged by the monitor
        repeat (8) @(negedge sys_clk);

        for (idx = 0; idx < ENTRY_NUM; idx++) begin
            send_sequence(idx);
        end
        @(negedge sys_clk);
        db_valid = 1'b0;
        db_first = 1'b0;
        db_last  = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge sys_clk);
        end
        repeat (seq_pkg::PE_NUM + 2) @(negedge sys_clk);

        $display("Summary: %0d checks, %0d errors", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        wait (timeout_cycles > 0);
        #(timeout_cycles * CLK_PERIOD);
        error_cnt++;
        $display("Watchdog timeout after %0d cycles", timeout_cycles);
        $display("Summary: %0d checks, %0d errors", check_cnt, error_cnt);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+sim
src/seq_pkg.sv
src/score_pkg.sv
src/sw_cell.sv
src/sw_best_tracker.sv
src/sw_top.sv
sim/tb_sw_top.sv

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_sw_top; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_sw_top)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

# Pass only if the testbench printed its pass line
if printf '%s\n' "$sim_out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
